// File: rtl/icache_bypass_defines.svh
// ================================================
// Instruction-cache bypass path configuration
// Port count, bus widths and order-queue depth
// ================================================

`ifndef ICACHE_BYPASS_DEFINES_SVH
`define ICACHE_BYPASS_DEFINES_SVH

// Fetch ports sharing the fill channel
`define NR_FETCH_PORTS 2
`define FETCH_AW       32
`define FETCH_DW       32
`define LINE_WIDTH     128
// Fills that may be outstanding at once, a power of two
`define ORDER_DEPTH    4

`endif

// File: rtl/icache_bypass_pkg.sv
// ================================================
// Instruction-cache bypass path types
// Shared packed structs and derived widths
// ================================================

`include "icache_bypass_defines.svh"

package icache_bypass_pkg;

  // Byte-offset bits within a line and within a fetch word
  localparam int unsigned LINE_ALIGN  = $clog2(`LINE_WIDTH / 8);
  localparam int unsigned FETCH_ALIGN = $clog2(`FETCH_DW / 8);

  // Index width for a single port, kept at least one bit wide
  localparam int unsigned PORT_IDX_W = (`NR_FETCH_PORTS > 1) ? $clog2(`NR_FETCH_PORTS) : 1;

  // One bit per fetch port, used for grants and order-queue entries
  typedef logic [`NR_FETCH_PORTS-1:0] port_mask_t;

  typedef struct packed {
    logic [`FETCH_DW-1:0] data;
    logic                 error;
  } fetch_rsp_t;

  // Address is always aligned to a line
  typedef struct packed {
    logic [`FETCH_AW-1:0] addr;
  } fill_req_t;

  typedef struct packed {
    logic [`LINE_WIDTH-1:0] data;
    logic                   error;
  } fill_rsp_t;

endpackage

// File: rtl/bypass_port_ctrl.sv
// ================================================
// Bypass fetch port controller
// Issues one line fill per fetch and presents the
// selected word for a single cycle
// ================================================

`timescale 1ns/1ps

`include "icache_bypass_defines.svh"

module bypass_port_ctrl (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic [`FETCH_AW-1:0]           inst_addr_i,
  input  logic                           inst_valid_i,
  output icache_bypass_pkg::fetch_rsp_t  inst_rsp_o,
  output logic                           inst_ready_o,
  input  logic                           order_full_i,
  output logic                           req_o,
  input  logic                           grant_i,
  input  logic                           fill_ready_i,
  input  logic                           rsp_strobe_i,
  input  icache_bypass_pkg::fill_rsp_t   fill_rsp_i
);

  import icache_bypass_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    RequestData,
    WaitResponse,
    PresentResponse
  } state_e;

  state_e                            state_q, state_d;
  logic [LINE_ALIGN-FETCH_ALIGN-1:0] word_sel;
  fetch_rsp_t                        rsp_q;

  // Word position of the fetch address inside its line
  assign word_sel   = inst_addr_i[LINE_ALIGN-1:FETCH_ALIGN];
  assign inst_rsp_o = rsp_q;

  always_comb begin
    state_d      = state_q;
    req_o        = 1'b0;
    inst_ready_o = 1'b0;
    unique case (state_q)
      Idle: begin
        if (inst_valid_i) begin
          state_d = RequestData;
        end
      end
      RequestData: begin
        // Only ask for the channel while the order queue can take the owner
        req_o = !order_full_i;
        if (req_o && grant_i && fill_ready_i) begin
          state_d = WaitResponse;
        end
      end
      WaitResponse: begin
        if (rsp_strobe_i) begin
          state_d = PresentResponse;
        end
      end
      PresentResponse: begin
        inst_ready_o = 1'b1;
        state_d      = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // The word is served from this register in the cycle after the fill returns
  always_ff @(posedge clk_i) begin
    if (rsp_strobe_i) begin
      rsp_q.data  <= fill_rsp_i.data[word_sel * `FETCH_DW +: `FETCH_DW];
      rsp_q.error <= fill_rsp_i.error;
    end
  end

endmodule

// File: rtl/bypass_rr_arbiter.sv
// ================================================
// Round-robin arbiter for the line-fill channel
// Holds a grant until the fill request is accepted
// ================================================

`timescale 1ns/1ps

`include "icache_bypass_defines.svh"

module bypass_rr_arbiter (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  icache_bypass_pkg::port_mask_t              req_i,
  input  logic [`NR_FETCH_PORTS-1:0][`FETCH_AW-1:0]  inst_addr_i,
  output icache_bypass_pkg::port_mask_t              grant_o,
  output icache_bypass_pkg::fill_req_t               fill_req_o,
  output logic                                       fill_req_valid_o,
  input  logic                                       fill_req_ready_i,
  output logic                                       push_o
);

  import icache_bypass_pkg::*;

  logic [PORT_IDX_W-1:0] rr_q;
  logic [PORT_IDX_W-1:0] lock_idx_q;
  logic [PORT_IDX_W-1:0] search_idx;
  logic [PORT_IDX_W-1:0] winner;
  logic                  lock_q;
  logic                  handshake;

  // First requesting port at or after the round-robin pointer
  always_comb begin : rr_search
    int unsigned cand;
    logic        found;
    cand       = 0;
    found      = 1'b0;
    search_idx = rr_q;
    for (int k = 0; k < `NR_FETCH_PORTS; k++) begin
      cand = (rr_q + k) % `NR_FETCH_PORTS;
      if (!found && req_i[cand]) begin
        search_idx = PORT_IDX_W'(cand);
        found      = 1'b1;
      end
    end
  end

  // A stalled request keeps its winner even if other ports join in
  assign winner           = lock_q ? lock_idx_q : search_idx;
  assign fill_req_valid_o = |req_i;
  assign grant_o          = fill_req_valid_o ? (port_mask_t'(1) << winner) : '0;
  assign fill_req_o.addr  = {inst_addr_i[winner][`FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  assign handshake        = fill_req_valid_o & fill_req_ready_i;
  assign push_o           = handshake;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (handshake) begin
      lock_q <= 1'b0;
      rr_q   <= (winner == PORT_IDX_W'(`NR_FETCH_PORTS - 1)) ? '0 : winner + 1'b1;
    end else if (fill_req_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= winner;
    end
  end

endmodule

// File: rtl/bypass_rsp_router.sv
// ================================================
// Fill response router
// Keeps the owner of each outstanding fill in order
// and strobes that port when its line returns
// ================================================

`timescale 1ns/1ps

`include "icache_bypass_defines.svh"

module bypass_rsp_router #(
  // Outstanding fills, a power of two of at least 2
  parameter int unsigned DEPTH = `ORDER_DEPTH
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           push_i,
  input  icache_bypass_pkg::port_mask_t  grant_i,
  output logic                           order_full_o,
  input  logic                           fill_rsp_valid_i,
  output logic                           fill_rsp_ready_o,
  output icache_bypass_pkg::port_mask_t  rsp_strobe_o
);

  import icache_bypass_pkg::*;

  localparam int unsigned PTR_W = $clog2(DEPTH);

  port_mask_t       order_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             pop;

  assign order_full_o     = (count_q == (PTR_W + 1)'(DEPTH));
  // Memory answers in order, so any response belongs to the head entry
  assign fill_rsp_ready_o = (count_q != '0);
  assign pop              = fill_rsp_valid_i & fill_rsp_ready_o;
  assign rsp_strobe_o     = pop ? order_q[rd_ptr_q] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Requests are held off while full, so a push never overwrites a live entry
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      order_q[wr_ptr_q] <= grant_i;
    end
  end

endmodule

// File: rtl/icache_bypass.sv
// ================================================
// Uncached instruction fetch path
// Several fetch ports share one line-fill channel
// ================================================

`timescale 1ns/1ps

`include "icache_bypass_defines.svh"

module icache_bypass (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  logic [`NR_FETCH_PORTS-1:0][`FETCH_AW-1:0]            inst_addr_i,
  input  logic [`NR_FETCH_PORTS-1:0]                           inst_valid_i,
  output icache_bypass_pkg::fetch_rsp_t [`NR_FETCH_PORTS-1:0]  inst_rsp_o,
  output logic [`NR_FETCH_PORTS-1:0]                           inst_ready_o,
  output icache_bypass_pkg::fill_req_t                         fill_req_o,
  output logic                                                 fill_req_valid_o,
  input  logic                                                 fill_req_ready_i,
  input  icache_bypass_pkg::fill_rsp_t                         fill_rsp_i,
  input  logic                                                 fill_rsp_valid_i,
  output logic                                                 fill_rsp_ready_o
);

  import icache_bypass_pkg::*;

  port_mask_t port_req;
  port_mask_t port_grant;
  port_mask_t rsp_strobe;
  logic       push;
  logic       order_full;

  // One controller per fetch port, all seeing the same fill response
  for (genvar i = 0; i < `NR_FETCH_PORTS; i++) begin : gen_port
    bypass_port_ctrl i_port_ctrl (
      .clk_i        ( clk_i            ),
      .arst_n_i     ( arst_n_i         ),
      .inst_addr_i  ( inst_addr_i[i]   ),
      .inst_valid_i ( inst_valid_i[i]  ),
      .inst_rsp_o   ( inst_rsp_o[i]    ),
      .inst_ready_o ( inst_ready_o[i]  ),
      .order_full_i ( order_full       ),
      .req_o        ( port_req[i]      ),
      .grant_i      ( port_grant[i]    ),
      .fill_ready_i ( fill_req_ready_i ),
      .rsp_strobe_i ( rsp_strobe[i]    ),
      .fill_rsp_i   ( fill_rsp_i       )
    );
  end

  bypass_rr_arbiter i_arbiter (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .req_i            ( port_req         ),
    .inst_addr_i      ( inst_addr_i      ),
    .grant_o          ( port_grant       ),
    .fill_req_o       ( fill_req_o       ),
    .fill_req_valid_o ( fill_req_valid_o ),
    .fill_req_ready_i ( fill_req_ready_i ),
    .push_o           ( push             )
  );

  bypass_rsp_router #(
    .DEPTH ( `ORDER_DEPTH )
  ) i_router (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .push_i           ( push             ),
    .grant_i          ( port_grant       ),
    .order_full_o     ( order_full       ),
    .fill_rsp_valid_i ( fill_rsp_valid_i ),
    .fill_rsp_ready_o ( fill_rsp_ready_o ),
    .rsp_strobe_o     ( rsp_strobe       )
  );

endmodule

// File: sim/icache_bypass_checker.sv
// ================================================
// Bypass fetch checker
// Tracks fill ownership on the DUT ports and checks
// each fetch response and its timing
// ================================================

`timescale 1ns/1ps

`include "icache_bypass_defines.svh"

module icache_bypass_checker (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  logic [`NR_FETCH_PORTS-1:0][`FETCH_AW-1:0]            inst_addr_i,
  input  logic [`NR_FETCH_PORTS-1:0]                           inst_valid_i,
  input  icache_bypass_pkg::fetch_rsp_t [`NR_FETCH_PORTS-1:0]  inst_rsp_i,
  input  logic [`NR_FETCH_PORTS-1:0]                           inst_ready_i,
  input  icache_bypass_pkg::fill_req_t                         fill_req_i,
  input  logic                                                 fill_req_valid_i,
  input  logic                                                 fill_req_ready_i,
  input  logic                                                 fill_rsp_valid_i,
  input  logic                                                 fill_rsp_ready_i,
  output int                                                   fetch_count_o,
  output int                                                   value_errors_o,
  output int                                                   protocol_errors_o
);

  import icache_bypass_pkg::*;

  int                         owner_q [$];
  int unsigned                cycle;
  int unsigned                due [`NR_FETCH_PORTS];
  logic [`FETCH_AW-1:0]       held_addr [`NR_FETCH_PORTS];
  logic [`NR_FETCH_PORTS-1:0] issued;
  logic [`NR_FETCH_PORTS-1:0] pending;
  logic                       started;
  logic                       req_stalled;
  logic [`FETCH_AW-1:0]       stalled_addr;

  initial begin
    cycle             = 0;
    issued            = '0;
    pending           = '0;
    started           = 1'b0;
    req_stalled       = 1'b0;
    stalled_addr      = '0;
    fetch_count_o     = 0;
    value_errors_o    = 0;
    protocol_errors_o = 0;
  end

  // A fill belongs to the waiting port whose address lies in the requested line
  function automatic int find_owner(input logic [`FETCH_AW-1:0] line_addr);
    for (int p = 0; p < `NR_FETCH_PORTS; p++) begin
      if (inst_valid_i[p] && !issued[p] &&
          (inst_addr_i[p] >> LINE_ALIGN) == (line_addr >> LINE_ALIGN)) begin
        return p;
      end
    end
    return -1;
  endfunction

  always @(posedge clk_i) begin : check_cycle
    int                   owner;
    logic [`FETCH_DW-1:0] exp_data;
    cycle++;
    if (arst_n_i && !started &&
        (inst_ready_i !== '0 || fill_req_valid_i !== 1'b0 || fill_rsp_ready_i !== 1'b0)) begin
      $display("Error: after reset inst_ready_o=%h fill_req_valid_o=%h fill_rsp_ready_o=%h",
               inst_ready_i, fill_req_valid_i, fill_rsp_ready_i);
      value_errors_o++;
    end
    started = started | (arst_n_i & (|inst_valid_i));
    if (arst_n_i) begin
      if (fill_rsp_ready_i !== (owner_q.size() != 0)) begin
        $display("Error: fill_rsp_ready_o=%h, expected %h", fill_rsp_ready_i,
                 owner_q.size() != 0);
        value_errors_o++;
      end
      // A fill request that was not taken keeps its valid and line address
      if (req_stalled && (fill_req_valid_i !== 1'b1 || fill_req_i.addr !== stalled_addr)) begin
        $display("Error: fill_req_o.addr=%h fill_req_valid_o=%h on a stall, expected addr=%h",
                 fill_req_i.addr, fill_req_valid_i, stalled_addr);
        value_errors_o++;
      end
      req_stalled  = fill_req_valid_i && !fill_req_ready_i;
      stalled_addr = fill_req_i.addr;
      // Responses come back in request order, so the oldest owner takes this one
      if (fill_rsp_valid_i && fill_rsp_ready_i) begin
        if (owner_q.size() == 0) begin
          $display("Fill response accepted at cycle %0d with no fill outstanding", cycle);
          protocol_errors_o++;
        end else begin
          owner            = owner_q.pop_front();
          pending[owner]   = 1'b1;
          due[owner]       = cycle + 1;
          held_addr[owner] = inst_addr_i[owner];
        end
      end
      if (fill_req_valid_i && fill_req_ready_i) begin
        owner = find_owner(fill_req_i.addr);
        if (fill_req_i.addr[LINE_ALIGN-1:0] !== '0) begin
          $display("Error: fill_req_o.addr=%h is not line aligned", fill_req_i.addr);
          value_errors_o++;
        end
        if (owner < 0) begin
          $display("Fill request for %h at cycle %0d matches no waiting fetch",
                   fill_req_i.addr, cycle);
          protocol_errors_o++;
        end else begin
          owner_q.push_back(owner);
          issued[owner] = 1'b1;
        end
      end
      for (int p = 0; p < `NR_FETCH_PORTS; p++) begin
        if (inst_ready_i[p]) begin
          if (!pending[p] || due[p] != cycle) begin
            $display("Port %0d pulsed inst_ready_o at cycle %0d without a fill one cycle before",
                     p, cycle);
            protocol_errors_o++;
          end else begin
            fetch_count_o++;
            exp_data = {held_addr[p][`FETCH_AW-1:2], 2'b00} ^ 32'hA5A5_0000;
            if (inst_rsp_i[p].data !== exp_data || inst_rsp_i[p].error !== held_addr[p][31]) begin
              $display("Error: inst_rsp_o[%0d] data=%h error=%h, expected data=%h error=%h",
                       p, inst_rsp_i[p].data, inst_rsp_i[p].error, exp_data, held_addr[p][31]);
              value_errors_o++;
            end
          end
          pending[p] = 1'b0;
          issued[p]  = 1'b0;
        end else if (pending[p] && cycle >= due[p]) begin
          $display("Port %0d missed its inst_ready_o pulse due at cycle %0d", p, due[p]);
          protocol_errors_o++;
          pending[p] = 1'b0;
          issued[p]  = 1'b0;
        end
      end
    end
  end

endmodule

// File: sim/tb_icache_bypass.sv
// ================================================
// Testbench for the uncached fetch path
// Feeds the fetch ports from a table and models
// the line-fill memory behind the DUT
// ================================================

`timescale 1ns/1ps

`include "icache_bypass_defines.svh"

module tb_icache_bypass;

  import icache_bypass_pkg::*;

  typedef struct packed {
    int unsigned          port;
    logic [`FETCH_AW-1:0] addr;
    logic                 err;
  } fetch_entry_t;

  localparam int unsigned ENTRIES = 14;

  logic                                      clk;
  logic                                      arst_n;
  logic [`NR_FETCH_PORTS-1:0][`FETCH_AW-1:0] inst_addr;
  logic [`NR_FETCH_PORTS-1:0]                inst_valid;
  fetch_rsp_t [`NR_FETCH_PORTS-1:0]          inst_rsp;
  logic [`NR_FETCH_PORTS-1:0]                inst_ready;
  fill_req_t                                 fill_req;
  logic                                      fill_req_valid;
  logic                                      fill_req_ready;
  fill_rsp_t                                 fill_rsp;
  logic                                      fill_rsp_valid;
  logic                                      fill_rsp_ready;
  fetch_entry_t                              fetch_tbl [ENTRIES];
  logic [`FETCH_AW-1:0]                      fill_q [$];
  logic [31:0]                               rng;
  int                                        rsp_wait;
  logic                                      rsp_taken;
  int                                        fetch_count;
  int                                        value_errors;
  int                                        protocol_errors;

  icache_bypass dut_i (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .inst_addr_i      ( inst_addr      ),
    .inst_valid_i     ( inst_valid     ),
    .inst_rsp_o       ( inst_rsp       ),
    .inst_ready_o     ( inst_ready     ),
    .fill_req_o       ( fill_req       ),
    .fill_req_valid_o ( fill_req_valid ),
    .fill_req_ready_i ( fill_req_ready ),
    .fill_rsp_i       ( fill_rsp       ),
    .fill_rsp_valid_i ( fill_rsp_valid ),
    .fill_rsp_ready_o ( fill_rsp_ready )
  );

  icache_bypass_checker i_checker (
    .clk_i             ( clk             ),
    .arst_n_i          ( arst_n          ),
    .inst_addr_i       ( inst_addr       ),
    .inst_valid_i      ( inst_valid      ),
    .inst_rsp_i        ( inst_rsp        ),
    .inst_ready_i      ( inst_ready      ),
    .fill_req_i        ( fill_req        ),
    .fill_req_valid_i  ( fill_req_valid  ),
    .fill_req_ready_i  ( fill_req_ready  ),
    .fill_rsp_valid_i  ( fill_rsp_valid  ),
    .fill_rsp_ready_i  ( fill_rsp_ready  ),
    .fetch_count_o     ( fetch_count     ),
    .value_errors_o    ( value_errors    ),
    .protocol_errors_o ( protocol_errors )
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Word k of a line holds its own address XORed with a fixed pattern
  function automatic fill_rsp_t make_line(input logic [`FETCH_AW-1:0] a);
    fill_rsp_t r;
    for (int k = 0; k < `LINE_WIDTH / `FETCH_DW; k++) begin
      r.data[k*`FETCH_DW +: `FETCH_DW] = (a + 4 * k) ^ 32'hA5A5_0000;
    end
    r.error = a[31];
    return r;
  endfunction

  always @(posedge clk) begin
    if (fill_req_valid && fill_req_ready) begin
      fill_q.push_back(fill_req.addr);
    end
    rsp_taken = fill_rsp_valid && fill_rsp_ready;
  end

  // Memory answers in request order after a random wait
  always @(negedge clk) begin
    rng            = xorshift(rng);
    fill_req_ready = rng[0] | rng[7];
    if (rsp_taken) begin
      fill_rsp_valid = 1'b0;
      void'(fill_q.pop_front());
      rsp_wait = 1 + rng[12:11];
    end else if (!fill_rsp_valid && fill_q.size() != 0) begin
      if (rsp_wait > 1) begin
        rsp_wait--;
      end else begin
        fill_rsp       = make_line(fill_q[0]);
        fill_rsp_valid = 1'b1;
      end
    end
  end

  initial begin : watchdog
    repeat (ENTRIES * 40) @(posedge clk);
    $display("Watchdog expired after %0d cycles with fetches still open", ENTRIES * 40);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    int idx;
    int p;
    clk            = 1'b0;
    arst_n         = 1'b0;
    inst_addr      = '0;
    inst_valid     = '0;
    fill_req_ready = 1'b0;
    fill_rsp       = '0;
    fill_rsp_valid = 1'b0;
    rng            = 32'd17;
    rsp_wait       = 0;
    rsp_taken      = 1'b0;
    // Port, address, error region; the error region sets address bit 31
    fetch_tbl = '{
      '{0, 32'h0000_1000, 1'b0}, '{0, 32'h0000_1006, 1'b0}, '{0, 32'h0000_100B, 1'b0},
      '{0, 32'h0000_100C, 1'b0}, '{0, 32'h0000_2008, 1'b1}, '{0, 32'h0000_3010, 1'b0},
      '{1, 32'h0000_4024, 1'b0}, '{0, 32'h0000_3038, 1'b0}, '{1, 32'h0000_403C, 1'b0},
      '{1, 32'h0000_4104, 1'b1}, '{0, 32'h0000_5004, 1'b0}, '{1, 32'h0000_6008, 1'b0},
      '{0, 32'h0000_500C, 1'b1}, '{1, 32'h0000_6FF0, 1'b0}
    };
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    repeat (3) @(negedge clk);
    idx = 0;
    while (idx < ENTRIES || inst_valid != '0) begin
      @(negedge clk);
      // A port whose response is showing is free to take its next entry
      inst_valid = inst_valid & ~inst_ready;
      while (idx < ENTRIES && !inst_valid[fetch_tbl[idx].port]) begin
        p             = fetch_tbl[idx].port;
        inst_addr[p]  = fetch_tbl[idx].addr | {fetch_tbl[idx].err, 31'd0};
        inst_valid[p] = 1'b1;
        idx++;
      end
    end
    repeat (4) @(negedge clk);
    $display("Fetches checked %0d of %0d, value errors %0d, protocol errors %0d",
             fetch_count, ENTRIES, value_errors, protocol_errors);
    if (fetch_count == ENTRIES && value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: icache_bypass.f
+incdir+rtl
rtl/icache_bypass_pkg.sv
rtl/bypass_port_ctrl.sv
rtl/bypass_rr_arbiter.sv
rtl/bypass_rsp_router.sv
rtl/icache_bypass.sv
sim/icache_bypass_checker.sv
sim/tb_icache_bypass.sv

// File: Bender.yml
package:
  name: icache_bypass

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/icache_bypass_pkg.sv
      - rtl/bypass_port_ctrl.sv
      - rtl/bypass_rr_arbiter.sv
      - rtl/bypass_rsp_router.sv
      - rtl/icache_bypass.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/icache_bypass_checker.sv
      - sim/tb_icache_bypass.sv
